/* tsglue_defines.svh */
`ifndef TSGLUE_DEFINES_SVH
`define TSGLUE_DEFINES_SVH

// z80 bus widths
`define TSG_ADDR_W 16
`define TSG_DATA_W 8

// low address byte of the border / beeper / tape port
`define TSG_PORT_FE 8'hFE

// covox sample port
`define TSG_PORT_FB 8'hFB

// saa1099 write port
`define TSG_PORT_SAA 8'hFF

// turbosound select, low nibble with a15 set
`define TSG_TS_NIBBLE 4'hD

// 28 MHz down to 3.5 MHz for the psg
`define TSG_YM_DIV 8

// cycles reset is held after all sources release
`define TSG_RST_STRETCH 16

`endif

/* tsglue_pkg.sv */
`default_nettype none
`include "tsglue_defines.svh"

package tsglue_pkg;

  // cpu bus straight from the z80 core
  typedef struct packed {
    logic [`TSG_ADDR_W-1:0] addr;
    logic [`TSG_DATA_W-1:0] dout;
    logic                   iorq_n;
    logic                   rd_n;
    logic                   wr_n;
  } z80_bus_t;

  // one-cycle port write events with their data byte
  typedef struct packed {
    logic                   fe_wr;
    logic                   fb_wr;
    logic [`TSG_DATA_W-1:0] data;
  } io_wr_t;

  // read selects decoded from the bus
  typedef struct packed {
    logic rom_rd;
    logic ts_rd;
    logic io_rd;
  } rd_sel_t;

  // read data from the cores around the glue
  typedef struct packed {
    logic [`TSG_DATA_W-1:0] rom;
    logic [`TSG_DATA_W-1:0] ram;
    logic [`TSG_DATA_W-1:0] ts;
    logic [`TSG_DATA_W-1:0] zifi;
    logic [`TSG_DATA_W-1:0] gs;
    logic [`TSG_DATA_W-1:0] fdc;
    logic [`TSG_DATA_W-1:0] ports;
    logic [`TSG_DATA_W-1:0] im2vect;
    logic                   ram_en;
    logic                   zifi_en;
    logic                   gs_en;
    logic                   fdc_en;
    logic                   ports_en;
    logic                   intack;
  } rd_sources_t;

  // which source drives the cpu data bus
  typedef enum logic [3:0] {
    RD_ROM,
    RD_RAM,
    RD_TS,
    RD_ZIFI,
    RD_GS,
    RD_FDC,
    RD_PORTS,
    RD_VECT,
    RD_NONE
  } rd_src_e;

  // phase counter of the psg clock enable
  typedef logic [$clog2(`TSG_YM_DIV)-1:0] ym_div_t;

endpackage

`default_nettype wire

/* reset_sync.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tsglue_defines.svh"

module reset_sync (
  input  logic clk_28mhz,
  input  logic rst,
  input  logic locked,
  input  logic resetbtn_n,
  output logic sys_rst
);

  localparam int unsigned CNT_W = $clog2(`TSG_RST_STRETCH + 1);

  logic [1:0]       rst_pipe;
  logic [1:0]       lock_pipe;
  logic [1:0]       btn_pipe;
  logic             src_active;
  logic [CNT_W-1:0] hold_cnt;

  // two-flop sync, rst delayed alike so every source releases in step
  always_ff @(posedge clk_28mhz) begin
    rst_pipe  <= {rst_pipe[0], rst};
    lock_pipe <= {lock_pipe[0], locked};
    btn_pipe  <= {btn_pipe[0], resetbtn_n};
  end

  assign src_active = rst | rst_pipe[1] | ~lock_pipe[1] | ~btn_pipe[1];

  // reload while any source is active, then count the stretch down
  always_ff @(posedge clk_28mhz) begin
    if (src_active) begin
      hold_cnt <= CNT_W'(`TSG_RST_STRETCH);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign sys_rst = src_active | (hold_cnt != '0);

endmodule

`default_nettype wire

/* cpu_bus_decode.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tsglue_defines.svh"

module cpu_bus_decode (
  input  logic                  clk_28mhz,
  input  logic                  sys_rst,
  input  tsglue_pkg::z80_bus_t  bus,
  input  logic                  mreq_n,
  input  logic                  csrom,
  input  logic                  covox_en,
  output tsglue_pkg::io_wr_t    io_wr,
  output tsglue_pkg::rd_sel_t   rd_sel,
  output logic                  ts_bdir,
  output logic                  ts_bc,
  output logic                  saa_wr_n
);

  logic                   io_wr_act;
  logic                   ts_sel;
  logic                   fe_hit;
  logic                   fb_hit;
  logic                   fe_hit_q;
  logic                   fb_hit_q;
  logic                   fe_start;
  logic                   fb_start;
  logic                   fe_wr_q;
  logic                   fb_wr_q;
  logic [`TSG_DATA_W-1:0] wr_data_q;

  assign io_wr_act = ~bus.iorq_n & ~bus.wr_n;

  // turbosound sits on every port with a15 set and low nibble D
  assign ts_sel = ~bus.iorq_n & bus.addr[15] & (bus.addr[3:0] == `TSG_TS_NIBBLE);

  assign fe_hit = io_wr_act & (bus.addr[7:0] == `TSG_PORT_FE);
  // covox port only exists when switched on from the osd
  assign fb_hit = io_wr_act & covox_en & (bus.addr[7:0] == `TSG_PORT_FB);

  // first cycle of a match only, a held write gives one event
  assign fe_start = fe_hit & ~fe_hit_q;
  assign fb_start = fb_hit & ~fb_hit_q;

  always_ff @(posedge clk_28mhz) begin
    if (sys_rst) begin
      fe_hit_q <= 1'b0;
      fb_hit_q <= 1'b0;
      fe_wr_q  <= 1'b0;
      fb_wr_q  <= 1'b0;
    end else begin
      fe_hit_q <= fe_hit;
      fb_hit_q <= fb_hit;
      fe_wr_q  <= fe_start;
      fb_wr_q  <= fb_start;
    end
  end

  // data byte travels with the pulse
  always_ff @(posedge clk_28mhz) begin
    if (fe_start | fb_start) begin
      wr_data_q <= bus.dout;
    end
  end

  assign io_wr = '{fe_wr: fe_wr_q, fb_wr: fb_wr_q, data: wr_data_q};

  assign rd_sel = '{
    rom_rd: csrom & ~mreq_n & ~bus.rd_n,
    ts_rd:  ts_sel & ~bus.rd_n,
    io_rd:  ~bus.iorq_n & ~bus.rd_n
  };

  // psg strobes go straight to the sound chips
  assign ts_bdir  = ts_sel & ~bus.wr_n;
  assign ts_bc    = bus.addr[14];
  assign saa_wr_n = ~(io_wr_act & (bus.addr[7:0] == `TSG_PORT_SAA));

endmodule

`default_nettype wire

/* port_latches.sv */
`timescale 1ns/10ps
`default_nettype none

module port_latches (
  input  logic                clk_28mhz,
  input  logic                sys_rst,
  input  tsglue_pkg::io_wr_t  io_wr,
  output logic [2:0]          border,
  output logic                tape_out,
  output logic                speaker,
  output logic [7:0]          covox_sample
);

  logic [7:0] port_fe_q;
  logic [7:0] port_fb_q;

  // #FE, border colour plus mic and ear bits
  always_ff @(posedge clk_28mhz) begin
    if (sys_rst) begin
      port_fe_q <= 8'h00;
    end else if (io_wr.fe_wr) begin
      port_fe_q <= io_wr.data;
    end
  end

  // #FB covox sample
  always_ff @(posedge clk_28mhz) begin
    if (sys_rst) begin
      port_fb_q <= 8'h00;
    end else if (io_wr.fb_wr) begin
      port_fb_q <= io_wr.data;
    end
  end

  assign border       = port_fe_q[2:0];
  assign tape_out     = port_fe_q[3];
  assign speaker      = port_fe_q[4];
  assign covox_sample = port_fb_q;

endmodule

`default_nettype wire

/* sound_int_timing.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tsglue_defines.svh"

module sound_int_timing (
  input  logic clk_28mhz,
  input  logic sys_rst,
  input  logic ftint,
  input  logic line_start,
  input  logic vdac2_sel,
  output logic ce_ym,
  output logic int_line
);

  tsglue_pkg::ym_div_t div;
  logic [1:0]          ftint_r;
  logic                ft_start;

  // 3.5 MHz enable, one pulse per divider turn
  always_ff @(posedge clk_28mhz) begin
    if (sys_rst) begin
      div   <= '0;
      ce_ym <= 1'b0;
    end else begin
      ce_ym <= (div == tsglue_pkg::ym_div_t'(`TSG_YM_DIV - 1));
      if (div == tsglue_pkg::ym_div_t'(`TSG_YM_DIV - 1)) begin
        div <= '0;
      end else begin
        div <= div + 1'b1;
      end
    end
  end

  // ft812 irq is active low, idle state is high
  always_ff @(posedge clk_28mhz) begin
    if (sys_rst) begin
      ftint_r  <= 2'b11;
      ft_start <= 1'b0;
    end else begin
      ftint_r  <= {ftint_r[0], ftint};
      ft_start <= ftint_r[1] & ~ftint_r[0];
    end
  end

  // second video dac replaces the line interrupt with the ft812 one
  assign int_line = vdac2_sel ? ft_start : line_start;

endmodule

`default_nettype wire

/* cpu_data_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_data_mux (
  input  tsglue_pkg::rd_sel_t      rd_sel,
  input  tsglue_pkg::rd_sources_t  src,
  output logic [7:0]               cpu_di,
  output tsglue_pkg::rd_src_e      rd_src
);

  // first active source wins, idle bus reads as #FF
  always_comb begin
    cpu_di = 8'hFF;
    rd_src = tsglue_pkg::RD_NONE;
    if (rd_sel.rom_rd) begin
      cpu_di = src.rom;
      rd_src = tsglue_pkg::RD_ROM;
    end else if (src.ram_en) begin
      cpu_di = src.ram;
      rd_src = tsglue_pkg::RD_RAM;
    end else if (rd_sel.ts_rd) begin
      cpu_di = src.ts;
      rd_src = tsglue_pkg::RD_TS;
    end else if (src.zifi_en) begin
      cpu_di = src.zifi;
      rd_src = tsglue_pkg::RD_ZIFI;
    end else if (src.gs_en) begin
      cpu_di = src.gs;
      rd_src = tsglue_pkg::RD_GS;
    end else if (src.fdc_en) begin
      cpu_di = src.fdc;
      rd_src = tsglue_pkg::RD_FDC;
    end else if (src.ports_en & rd_sel.io_rd) begin
      // port data only counts during an i/o read
      cpu_di = src.ports;
      rd_src = tsglue_pkg::RD_PORTS;
    end else if (src.intack) begin
      cpu_di = src.im2vect;
      rd_src = tsglue_pkg::RD_VECT;
    end
  end

endmodule

`default_nettype wire

/* tsglue_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tsglue_top (
  input  logic                     clk_28mhz,
  input  logic                     rst,
  input  logic                     locked,
  input  logic                     resetbtn_n,
  input  tsglue_pkg::z80_bus_t     bus,
  input  logic                     mreq_n,
  input  logic                     csrom,
  input  logic                     covox_en,
  input  tsglue_pkg::rd_sources_t  src,
  input  logic                     ftint,
  input  logic                     line_start,
  input  logic                     vdac2_sel,
  output logic                     sys_rst,
  output logic [2:0]               border,
  output logic                     tape_out,
  output logic                     speaker,
  output logic [7:0]               covox_sample,
  output logic [7:0]               cpu_di,
  output tsglue_pkg::rd_src_e      rd_src,
  output logic                     ts_bdir,
  output logic                     ts_bc,
  output logic                     saa_wr_n,
  output logic                     ce_ym,
  output logic                     int_line
);

  tsglue_pkg::io_wr_t  io_wr;
  tsglue_pkg::rd_sel_t rd_sel;

  reset_sync reset_sync_inst (
    .clk_28mhz  (clk_28mhz),
    .rst        (rst),
    .locked     (locked),
    .resetbtn_n (resetbtn_n),
    .sys_rst    (sys_rst)
  );

  cpu_bus_decode cpu_bus_decode_inst (
    .clk_28mhz (clk_28mhz),
    .sys_rst   (sys_rst),
    .bus       (bus),
    .mreq_n    (mreq_n),
    .csrom     (csrom),
    .covox_en  (covox_en),
    .io_wr     (io_wr),
    .rd_sel    (rd_sel),
    .ts_bdir   (ts_bdir),
    .ts_bc     (ts_bc),
    .saa_wr_n  (saa_wr_n)
  );

  port_latches port_latches_inst (
    .clk_28mhz    (clk_28mhz),
    .sys_rst      (sys_rst),
    .io_wr        (io_wr),
    .border       (border),
    .tape_out     (tape_out),
    .speaker      (speaker),
    .covox_sample (covox_sample)
  );

  sound_int_timing sound_int_timing_inst (
    .clk_28mhz  (clk_28mhz),
    .sys_rst    (sys_rst),
    .ftint      (ftint),
    .line_start (line_start),
    .vdac2_sel  (vdac2_sel),
    .ce_ym      (ce_ym),
    .int_line   (int_line)
  );

  cpu_data_mux cpu_data_mux_inst (
    .rd_sel (rd_sel),
    .src    (src),
    .cpu_di (cpu_di),
    .rd_src (rd_src)
  );

endmodule

`default_nettype wire

/* tb_tsglue.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tsglue_defines.svh"

module tb_tsglue;

  parameter logic [31:0] SEED = 32'h2e478c50;

  localparam int CLK_NS    = 4;
  localparam int RESET_CYC = 80;
  localparam int CE_CYC    = 100 * `TSG_YM_DIV;
  localparam int WRITE_CYC = 200 * 6;
  localparam int READ_CYC  = 300;
  localparam int STRB_CYC  = 200;
  localparam int INT_CYC   = 400;
  localparam int TOTAL_CYC = RESET_CYC + CE_CYC + WRITE_CYC + READ_CYC + STRB_CYC + INT_CYC;

  logic                    clk_28mhz;
  logic                    rst;
  logic                    locked;
  logic                    resetbtn_n;
  tsglue_pkg::z80_bus_t    bus;
  logic                    mreq_n;
  logic                    csrom;
  logic                    covox_en;
  tsglue_pkg::rd_sources_t src;
  logic                    ftint;
  logic                    line_start;
  logic                    vdac2_sel;
  logic                    sys_rst;
  logic [2:0]              border;
  logic                    tape_out;
  logic                    speaker;
  logic [7:0]              covox_sample;
  logic [7:0]              cpu_di;
  tsglue_pkg::rd_src_e     rd_src;
  logic                    ts_bdir;
  logic                    ts_bc;
  logic                    saa_wr_n;
  logic                    ce_ym;
  logic                    int_line;

  int checks;
  int errors;
  int test_err0;

  tsglue_top tsglue_top_inst (.*);

  initial begin
    clk_28mhz = 1'b0;
    forever #(CLK_NS / 2.0) clk_28mhz = ~clk_28mhz;
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  // counts negedges until sys_rst is seen low
  task automatic wait_reset_low(output int cycles);
    cycles = 0;
    @(negedge clk_28mhz);
    while (sys_rst && cycles < 64) begin
      cycles++;
      @(negedge clk_28mhz);
    end
    checks++;
    assert (!sys_rst) else begin
      errors++;
      $display("sys_rst still high %0d cycles after its sources released", cycles);
    end
  endtask

  task automatic test_reset();
    int cycles;
    repeat (10) @(posedge clk_28mhz);
    rst <= 1'b0;
    wait_reset_low(cycles);
    check_eq("reset fe", 32'd0, 32'({speaker, tape_out, border}));
    check_eq("reset fb", 32'd0, 32'(covox_sample));
    // load both latches so the button reset has something to clear
    @(posedge clk_28mhz);
    bus <= '{addr: {8'h00, `TSG_PORT_FE}, dout: 8'hFF,
             iorq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0};
    covox_en <= 1'b1;
    @(posedge clk_28mhz);
    bus.addr <= {8'h00, `TSG_PORT_FB};
    @(posedge clk_28mhz);
    bus      <= '{addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
    covox_en <= 1'b0;
    @(posedge clk_28mhz);
    resetbtn_n <= 1'b0;
    repeat (4) @(posedge clk_28mhz);
    @(negedge clk_28mhz);
    check_eq("button reset", 32'd1, 32'(sys_rst));
    @(posedge clk_28mhz);
    resetbtn_n <= 1'b1;
    wait_reset_low(cycles);
    checks++;
    assert (cycles >= `TSG_RST_STRETCH) else begin
      errors++;
      $display("sys_rst fell only %0d cycles after button release", cycles);
    end
    check_eq("button reset fe", 32'd0, 32'({speaker, tape_out, border}));
    check_eq("button reset fb", 32'd0, 32'(covox_sample));
    finish_test("reset");
  endtask

  // starts on the first negedge with sys_rst low, counted as cycle 0
  task automatic test_ce_ym();
    int pulses = 0;
    for (int cyc = 1; cyc <= CE_CYC; cyc++) begin
      @(negedge clk_28mhz);
      check_eq("ce_ym", 32'(cyc % `TSG_YM_DIV == 0), 32'(ce_ym));
      if (ce_ym) begin
        pulses++;
      end
    end
    check_eq("ce_ym pulses", 32'(CE_CYC / `TSG_YM_DIV), 32'(pulses));
    finish_test("ce_ym");
  endtask

  task automatic test_port_writes();
    logic [7:0]           model_fe;
    logic [7:0]           model_fb;
    tsglue_pkg::z80_bus_t wb;
    tsglue_pkg::z80_bus_t idle;
    int                   len;
    logic                 cov;
    model_fe = 8'h00;
    model_fb = 8'h00;
    idle = '{addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
    for (int i = 0; i < 200; i++) begin
      wb = idle;
      wb.addr = 16'($urandom);
      case ($urandom % 4)
        0: wb.addr[7:0] = `TSG_PORT_FE;
        1: wb.addr[7:0] = `TSG_PORT_FB;
        2: wb.addr[7:0] = `TSG_PORT_SAA;
        default: ;
      endcase
      wb.dout   = 8'($urandom);
      wb.iorq_n = 1'b0;
      wb.wr_n   = 1'b0;
      len = 1 + int'($urandom % 4);
      cov = 1'($urandom);
      if (wb.addr[7:0] == `TSG_PORT_FE) begin
        model_fe = wb.dout;
      end
      if (wb.addr[7:0] == `TSG_PORT_FB && cov) begin
        model_fb = wb.dout;
      end
      // held for len cycles, then at least one idle cycle
      for (int k = 0; k < len + 2; k++) begin
        @(posedge clk_28mhz);
        if (k == 0) begin
          bus      <= wb;
          covox_en <= cov;
        end
        if (k == len) begin
          bus <= idle;
        end
        if (k == 2) begin
          @(negedge clk_28mhz);
          check_eq("port_write fe", 32'(model_fe[4:0]), 32'({speaker, tape_out, border}));
          check_eq("port_write fb", 32'(model_fb), 32'(covox_sample));
        end
      end
    end
    finish_test("port_writes");
  endtask

  task automatic test_read_mux();
    tsglue_pkg::rd_sources_t s;
    tsglue_pkg::z80_bus_t    b;
    logic                    rom_rd;
    logic                    io_rd;
    logic                    ts_rd;
    logic [7:0]              act;
    logic [7:0][7:0]         dat;
    logic [7:0]              exp_di;
    tsglue_pkg::rd_src_e     exp_src;
    for (int i = 0; i < READ_CYC; i++) begin
      for (int j = 0; j < 8; j++) begin
        s[6 + 8 * j +: 8] = 8'($urandom);
      end
      // enables are sparse so lower priorities also win
      for (int j = 0; j < 6; j++) begin
        s[j] = ($urandom % 4 == 0);
      end
      b.addr = 16'($urandom);
      if ($urandom % 2 == 0) begin
        b.addr[3:0] = `TSG_TS_NIBBLE;
      end
      b.dout   = 8'h00;
      b.iorq_n = 1'($urandom);
      b.rd_n   = 1'($urandom);
      b.wr_n   = 1'b1;
      @(posedge clk_28mhz);
      src    <= s;
      bus    <= b;
      mreq_n <= 1'($urandom);
      csrom  <= 1'($urandom);
      @(negedge clk_28mhz);
      rom_rd = csrom & ~mreq_n & ~bus.rd_n;
      io_rd  = ~bus.iorq_n & ~bus.rd_n;
      ts_rd  = io_rd & bus.addr[15] & (bus.addr[3:0] == `TSG_TS_NIBBLE);
      act = {rom_rd, src.ram_en, ts_rd, src.zifi_en, src.gs_en, src.fdc_en,
             src.ports_en & io_rd, src.intack};
      dat = {src.rom, src.ram, src.ts, src.zifi, src.gs, src.fdc, src.ports, src.im2vect};
      exp_di  = 8'hFF;
      exp_src = tsglue_pkg::RD_NONE;
      // lowest priority first, the last hit wins
      for (int j = 0; j < 8; j++) begin
        if (act[j]) begin
          exp_di  = dat[j];
          exp_src = tsglue_pkg::rd_src_e'(4'(7 - j));
        end
      end
      check_eq("read cpu_di", 32'(exp_di), 32'(cpu_di));
      check_eq("read rd_src", 32'(exp_src), 32'(rd_src));
    end
    finish_test("read_mux");
  endtask

  task automatic test_strobes();
    tsglue_pkg::z80_bus_t b;
    logic [2:0]           exp;
    for (int i = 0; i < STRB_CYC; i++) begin
      b.addr = 16'($urandom);
      case ($urandom % 3)
        0: b.addr[7:0] = `TSG_PORT_SAA;
        1: b.addr[3:0] = `TSG_TS_NIBBLE;
        default: ;
      endcase
      b.dout   = 8'($urandom);
      b.iorq_n = 1'($urandom);
      b.rd_n   = 1'($urandom);
      b.wr_n   = 1'($urandom);
      @(posedge clk_28mhz);
      bus <= b;
      @(negedge clk_28mhz);
      exp[2] = ~b.iorq_n & ~b.wr_n & b.addr[15] & (b.addr[3:0] == `TSG_TS_NIBBLE);
      exp[1] = b.addr[14];
      exp[0] = ~(~b.iorq_n & ~b.wr_n & (b.addr[7:0] == `TSG_PORT_SAA));
      check_eq("strobes", 32'(exp), 32'({ts_bdir, ts_bc, saa_wr_n}));
    end
    finish_test("strobes");
  endtask

  task automatic test_interrupts();
    logic [3:0] hist;
    logic       f;
    logic       sel;
    logic       exp_ft;
    // ftint history, bit 0 is the current cycle
    hist = 4'b1111;
    sel  = 1'b1;
    for (int i = 0; i < INT_CYC; i++) begin
      f = ($urandom % 5 == 0) ? ~hist[0] : hist[0];
      if ($urandom % 32 == 0) begin
        sel = ~sel;
      end
      @(posedge clk_28mhz);
      ftint      <= f;
      vdac2_sel  <= sel;
      line_start <= ($urandom % 8 == 0);
      hist = {hist[2:0], f};
      @(negedge clk_28mhz);
      exp_ft = hist[3] & ~hist[2];
      check_eq("int_line", 32'(sel ? exp_ft : line_start), 32'(int_line));
    end
    finish_test("interrupts");
  endtask

  initial begin
    void'($urandom(SEED));
    checks     = 0;
    errors     = 0;
    test_err0  = 0;
    rst        = 1'b1;
    locked     = 1'b1;
    resetbtn_n = 1'b1;
    bus        = '{addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
    mreq_n     = 1'b1;
    csrom      = 1'b0;
    covox_en   = 1'b0;
    src        = '0;
    ftint      = 1'b1;
    line_start = 1'b0;
    vdac2_sel  = 1'b0;
    test_reset();
    test_ce_ym();
    test_port_writes();
    test_read_mux();
    test_strobes();
    test_interrupts();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(2 * TOTAL_CYC * CLK_NS);
    $display("watchdog expired after %0d cycles, the tests did not finish", 2 * TOTAL_CYC);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
tsglue_pkg.sv
reset_sync.sv
cpu_bus_decode.sv
port_latches.sv
sound_int_timing.sv
cpu_data_mux.sv
tsglue_top.sv
tb_tsglue.sv

/* Makefile */
# Verilator simulation of the bus glue testbench

VERILATOR ?= verilator
TOP       ?= tb_tsglue
# 32'h2e478c50 in decimal
SEED      ?= 776440912
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f build.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
